//--- verilog/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath
`define XLEN 32
`define IMM_W 16
`define SHAMT_W 5

// Register file
`define REG_ADDR_W 5
`define NUM_REGS 32

// Instruction fields
`define OPCODE_W 6
`define FUNCT_W 6

// Control encodings
`define ALU_OP_W 4
`define EXC_W 3

`endif

//--- verilog/cpu_pkg.sv
`default_nettype none
`include "cpu_macros.svh"

package cpu_pkg;

	typedef enum logic [`OPCODE_W-1:0] {
		OP_SPECIAL = 6'h00,
		OP_ADDI    = 6'h08,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f
	} opcode_e;

	typedef enum logic [`FUNCT_W-1:0] {
		F_SLL     = 6'h00,
		F_SRL     = 6'h02,
		F_SYSCALL = 6'h0c,
		F_BREAK   = 6'h0d,
		F_ADD     = 6'h20,
		F_ADDU    = 6'h21,
		F_SUB     = 6'h22,
		F_SUBU    = 6'h23,
		F_AND     = 6'h24,
		F_OR      = 6'h25,
		F_XOR     = 6'h26,
		F_NOR     = 6'h27,
		F_SLT     = 6'h2a
	} funct_e;

	typedef enum logic [`ALU_OP_W-1:0] {
		ALU_ADD   = 4'd0, // Zero so a bubble decodes as add
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_OR    = 4'd3,
		ALU_XOR   = 4'd4,
		ALU_NOR   = 4'd5,
		ALU_SLT   = 4'd6,
		ALU_SLL   = 4'd7,
		ALU_SRL   = 4'd8,
		ALU_PASSB = 4'd9
	} alu_op_e;

	typedef enum logic [`EXC_W-1:0] {
		EXC_NONE     = 3'd0,
		EXC_OVERFLOW = 3'd1,
		EXC_SYSCALL  = 3'd2,
		EXC_BREAK    = 3'd3,
		EXC_RESERVED = 3'd4
	} exc_e;

	typedef struct packed {
		logic [`XLEN-1:0]       porta;
		logic [`XLEN-1:0]       portb;
		alu_op_e                alu_op;
		logic                   we;
		logic [`REG_ADDR_W-1:0] waddr;
		logic                   ovf_check; // Signed add/sub
		logic                   syscall_op;
		logic                   break_op;
		logic                   reserved_op;
	} idex_bundle_t;

endpackage

`default_nettype wire

//--- verilog/idex_if.sv
`default_nettype none
`include "cpu_macros.svh"

interface idex_if
	import cpu_pkg::*;
();

	idex_bundle_t           id_bundle;
	idex_bundle_t           ex_bundle;

	// Result of the instruction in EX, back to decode
	logic                   fwd_we;
	logic [`REG_ADDR_W-1:0] fwd_waddr;
	logic [`XLEN-1:0]       fwd_data;

	modport decode (
		output id_bundle,
		input  fwd_we,
		input  fwd_waddr,
		input  fwd_data
	);

	modport register (
		input  id_bundle,
		output ex_bundle
	);

	modport execute (
		input  ex_bundle,
		output fwd_we,
		output fwd_waddr,
		output fwd_data
	);

endinterface

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none
`include "cpu_macros.svh"

module reg_file (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic [`REG_ADDR_W-1:0] raddr_a,
	input  wire logic [`REG_ADDR_W-1:0] raddr_b,
	output logic      [`XLEN-1:0]       rdata_a,
	output logic      [`XLEN-1:0]       rdata_b,
	input  wire logic                   we,
	input  wire logic [`REG_ADDR_W-1:0] waddr,
	input  wire logic [`XLEN-1:0]       wdata
);

	logic [`XLEN-1:0] regs [`NUM_REGS];
	logic             wr_en;

	assign wr_en = we && (waddr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[waddr] <= wdata;
		end
	end

	// Same-cycle write bypasses to the reads
	assign rdata_a = (wr_en && waddr == raddr_a) ? wdata : regs[raddr_a];
	assign rdata_b = (wr_en && waddr == raddr_b) ? wdata : regs[raddr_b];

	// A write to r0 never shows up on a later read
	a_r0_zero: assert property (@(posedge clk) disable iff (rst)
		(raddr_a == '0) |-> (rdata_a == '0));

endmodule

`default_nettype wire

//--- verilog/id_decode.sv
`default_nettype none
`include "cpu_macros.svh"

module id_decode
	import cpu_pkg::*;
(
	input  wire logic [`XLEN-1:0]       instr,
	input  wire logic                   instr_valid,
	input  wire logic [`XLEN-1:0]       rdata_a,
	input  wire logic [`XLEN-1:0]       rdata_b,
	output logic      [`REG_ADDR_W-1:0] raddr_a,
	output logic      [`REG_ADDR_W-1:0] raddr_b,
	idex_if.decode                      bus
);

	opcode_e                opcode;
	funct_e                 funct;
	logic [`REG_ADDR_W-1:0] rs;
	logic [`REG_ADDR_W-1:0] rt;
	logic [`REG_ADDR_W-1:0] rd;
	logic [`SHAMT_W-1:0]    shamt;
	logic [`IMM_W-1:0]      imm;
	logic [`XLEN-1:0]       imm_sext;
	logic [`XLEN-1:0]       imm_zext;
	logic [`XLEN-1:0]       imm_lui;
	logic [`XLEN-1:0]       op_a;
	logic [`XLEN-1:0]       op_b;
	idex_bundle_t           dec;

	assign opcode = opcode_e'(instr[31:26]);
	assign funct  = funct_e'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign shamt  = instr[10:6];
	assign imm    = instr[15:0];

	assign imm_sext = {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};
	assign imm_zext = {{(`XLEN-`IMM_W){1'b0}}, imm};
	assign imm_lui  = {imm, {(`XLEN-`IMM_W){1'b0}}};

	assign raddr_a = rs;
	assign raddr_b = rt;

	// Distance one comes from EX, distance two from the register file bypass
	assign op_a = (bus.fwd_we && bus.fwd_waddr == rs) ? bus.fwd_data : rdata_a;
	assign op_b = (bus.fwd_we && bus.fwd_waddr == rt) ? bus.fwd_data : rdata_b;

	always_comb begin
		dec       = '0;
		dec.porta = op_a;
		dec.portb = op_b;
		dec.we    = 1'b1;
		dec.waddr = rt;
		case (opcode)
			OP_SPECIAL: begin
				dec.waddr = rd;
				case (funct)
					F_ADD: dec.ovf_check = 1'b1;
					F_ADDU: dec.alu_op = ALU_ADD;
					F_SUB: begin
						dec.alu_op    = ALU_SUB;
						dec.ovf_check = 1'b1;
					end
					F_SUBU: dec.alu_op = ALU_SUB;
					F_AND: dec.alu_op = ALU_AND;
					F_OR: dec.alu_op = ALU_OR;
					F_XOR: dec.alu_op = ALU_XOR;
					F_NOR: dec.alu_op = ALU_NOR;
					F_SLT: dec.alu_op = ALU_SLT;
					F_SLL: begin
						dec.alu_op = ALU_SLL;
						dec.porta  = {{(`XLEN-`SHAMT_W){1'b0}}, shamt};
					end
					F_SRL: begin
						dec.alu_op = ALU_SRL;
						dec.porta  = {{(`XLEN-`SHAMT_W){1'b0}}, shamt};
					end
					F_SYSCALL: begin
						dec.syscall_op = 1'b1;
						dec.we         = 1'b0;
					end
					F_BREAK: begin
						dec.break_op = 1'b1;
						dec.we       = 1'b0;
					end
					default: begin
						dec.reserved_op = 1'b1;
						dec.we          = 1'b0;
					end
				endcase
			end
			OP_ADDI: begin
				dec.portb     = imm_sext;
				dec.ovf_check = 1'b1;
			end
			OP_ADDIU: dec.portb = imm_sext;
			OP_SLTI: begin
				dec.alu_op = ALU_SLT;
				dec.portb  = imm_sext;
			end
			OP_ANDI: begin
				dec.alu_op = ALU_AND;
				dec.portb  = imm_zext;
			end
			OP_ORI: begin
				dec.alu_op = ALU_OR;
				dec.portb  = imm_zext;
			end
			OP_XORI: begin
				dec.alu_op = ALU_XOR;
				dec.portb  = imm_zext;
			end
			OP_LUI: begin
				dec.alu_op = ALU_PASSB;
				dec.portb  = imm_lui;
			end
			default: begin
				dec.reserved_op = 1'b1;
				dec.we          = 1'b0;
			end
		endcase
		if (dec.waddr == '0)
			dec.we = 1'b0; // r0 stays zero
	end

	assign bus.id_bundle = instr_valid ? dec : '0; // Empty slot is a bubble

endmodule

`default_nettype wire

//--- verilog/idex_reg.sv
`default_nettype none
`include "cpu_macros.svh"

module idex_reg
	import cpu_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic stall,
	input  wire logic flush,
	idex_if.register  bus
);

	always_ff @(posedge clk) begin
		if (rst || flush)
			bus.ex_bundle <= '0;
		else if (!stall)
			bus.ex_bundle <= bus.id_bundle;
	end

	// An exception in EX leaves a bubble behind it
	a_flush_bubble: assert property (@(posedge clk) disable iff (rst)
		(flush && !stall) |=> (bus.ex_bundle == '0));

endmodule

`default_nettype wire

//--- verilog/ex_stage.sv
`default_nettype none
`include "cpu_macros.svh"

module ex_stage
	import cpu_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   hold,
	idex_if.execute                     bus,
	output logic                        flush,
	output logic                        wb_we,
	output logic      [`REG_ADDR_W-1:0] wb_waddr,
	output logic      [`XLEN-1:0]       wb_data,
	output logic                        exc_valid,
	output exc_e                        exc_code
);

	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [`XLEN-1:0] alu_res;
	logic             ovf;
	exc_e             exc_sel;
	logic             exc_now;

	assign a = bus.ex_bundle.porta;
	assign b = bus.ex_bundle.portb;

	always_comb begin
		case (bus.ex_bundle.alu_op)
			ALU_ADD: alu_res = a + b;
			ALU_SUB: alu_res = a - b;
			ALU_AND: alu_res = a & b;
			ALU_OR: alu_res = a | b;
			ALU_XOR: alu_res = a ^ b;
			ALU_NOR: alu_res = ~(a | b);
			ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLL: alu_res = b << a[`SHAMT_W-1:0];
			ALU_SRL: alu_res = b >> a[`SHAMT_W-1:0];
			ALU_PASSB: alu_res = b;
			default: alu_res = '0;
		endcase
	end

	// Sign of the result disagrees with the operands
	always_comb begin
		ovf = 1'b0;
		if (bus.ex_bundle.ovf_check) begin
			if (bus.ex_bundle.alu_op == ALU_SUB)
				ovf = (a[`XLEN-1] != b[`XLEN-1]) && (alu_res[`XLEN-1] != a[`XLEN-1]);
			else
				ovf = (a[`XLEN-1] == b[`XLEN-1]) && (alu_res[`XLEN-1] != a[`XLEN-1]);
		end
	end

	always_comb begin
		if (bus.ex_bundle.reserved_op)
			exc_sel = EXC_RESERVED;
		else if (bus.ex_bundle.syscall_op)
			exc_sel = EXC_SYSCALL;
		else if (bus.ex_bundle.break_op)
			exc_sel = EXC_BREAK;
		else if (ovf)
			exc_sel = EXC_OVERFLOW;
		else
			exc_sel = EXC_NONE;
	end

	assign exc_now = (exc_sel != EXC_NONE);
	assign flush   = exc_now && !hold; // Kills the instruction behind

	assign bus.fwd_we    = bus.ex_bundle.we && !exc_now;
	assign bus.fwd_waddr = bus.ex_bundle.waddr;
	assign bus.fwd_data  = alu_res;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_we     <= 1'b0;
			exc_valid <= 1'b0;
			exc_code  <= EXC_NONE;
		end else if (!hold) begin
			wb_we     <= bus.ex_bundle.we && !exc_now;
			exc_valid <= exc_now;
			exc_code  <= exc_sel;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			wb_waddr <= bus.ex_bundle.waddr;
			wb_data  <= alu_res;
		end
	end

	a_wb_xor_exc: assert property (@(posedge clk) disable iff (rst)
		!(wb_we && exc_valid));

endmodule

`default_nettype wire

//--- verilog/cpu_idex_top.sv
`default_nettype none
`include "cpu_macros.svh"

module cpu_idex_top (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   hold,
	input  wire logic                   instr_valid,
	input  wire logic [`XLEN-1:0]       instr,
	output logic                        result_we,
	output logic      [`REG_ADDR_W-1:0] result_waddr,
	output logic      [`XLEN-1:0]       result_data,
	output logic                        exc_valid,
	output logic      [`EXC_W-1:0]      exc_code
);

	logic [`REG_ADDR_W-1:0] raddr_a;
	logic [`REG_ADDR_W-1:0] raddr_b;
	logic [`XLEN-1:0]       rdata_a;
	logic [`XLEN-1:0]       rdata_b;
	logic                   flush;

	idex_if idex ();

	reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.raddr_a (raddr_a),
		.raddr_b (raddr_b),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b),
		.we      (result_we), // Written from the writeback register
		.waddr   (result_waddr),
		.wdata   (result_data)
	);

	id_decode u_id_decode (
		.instr       (instr),
		.instr_valid (instr_valid),
		.rdata_a     (rdata_a),
		.rdata_b     (rdata_b),
		.raddr_a     (raddr_a),
		.raddr_b     (raddr_b),
		.bus         (idex.decode)
	);

	idex_reg u_idex_reg (
		.clk   (clk),
		.rst   (rst),
		.stall (hold),
		.flush (flush),
		.bus   (idex.register)
	);

	ex_stage u_ex_stage (
		.clk       (clk),
		.rst       (rst),
		.hold      (hold),
		.bus       (idex.execute),
		.flush     (flush),
		.wb_we     (result_we),
		.wb_waddr  (result_waddr),
		.wb_data   (result_data),
		.exc_valid (exc_valid),
		.exc_code  (exc_code)
	);

endmodule

`default_nettype wire

//--- verif/tb_cpu_idex.sv
`default_nettype none

module tb_cpu_idex;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_LINES = 128;

	logic        clk;
	logic        rst;
	logic        hold;
	logic        instr_valid;
	logic [31:0] instr;
	logic        result_we;
	logic [4:0]  result_waddr;
	logic [31:0] result_data;
	logic        exc_valid;
	logic [2:0]  exc_code;

	string       t_name [MAX_LINES];
	logic [31:0] t_instr [MAX_LINES];
	logic        t_valid [MAX_LINES];
	logic        t_hold [MAX_LINES];
	logic        e_we [MAX_LINES];
	logic [4:0]  e_waddr [MAX_LINES];
	logic [31:0] e_data [MAX_LINES];
	logic        e_exc [MAX_LINES];
	logic [2:0]  e_code [MAX_LINES];

	int          n_lines;
	int          errors;
	int          checks;
	int          cycles;
	int          seed;
	int          limit = 1000;
	int          pend [$]; // Line index per slot in flight, -1 for filler

	logic        last_we;
	logic [4:0]  last_waddr;
	logic [31:0] last_data;
	logic        last_exc;
	logic [2:0]  last_code;

	cpu_idex_top dut (
		.clk          (clk),
		.rst          (rst),
		.hold         (hold),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.result_we    (result_we),
		.result_waddr (result_waddr),
		.result_data  (result_data),
		.exc_valid    (exc_valid),
		.exc_code     (exc_code)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, results did not drain", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic read_patterns();
		int          fd;
		int          cnt;
		string       line;
		string       name;
		logic [31:0] ins;
		logic [31:0] data;
		int          v;
		int          h;
		int          we;
		int          wa;
		int          ex;
		int          code;
		n_lines = 0;
		fd = $fopen("verif/idex_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/idex_patterns.txt");
			errors++;
		end else begin
			while (!$feof(fd) && n_lines < MAX_LINES) begin
				line = "";
				cnt = $fgets(line, fd);
				if (line.len() > 1 && line.getc(0) != "#") begin
					cnt = $sscanf(line, "%s %h %d %d %d %d %h %d %d",
						name, ins, v, h, we, wa, data, ex, code);
					if (cnt == 9) begin
						t_name[n_lines]  = name;
						t_instr[n_lines] = ins;
						t_valid[n_lines] = v[0];
						t_hold[n_lines]  = h[0];
						e_we[n_lines]    = we[0];
						e_waddr[n_lines] = wa[4:0];
						e_data[n_lines]  = data;
						e_exc[n_lines]   = ex[0];
						e_code[n_lines]  = code[2:0];
						n_lines++;
					end else begin
						$display("pattern line is malformed: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic compare_result(input int k);
		check({t_name[k], " we"}, {31'b0, e_we[k]}, {31'b0, result_we});
		check({t_name[k], " exc_valid"}, {31'b0, e_exc[k]}, {31'b0, exc_valid});
		if (e_we[k]) begin
			check({t_name[k], " waddr"}, {27'b0, e_waddr[k]}, {27'b0, result_waddr});
			check({t_name[k], " data"}, e_data[k], result_data);
		end
		if (e_exc[k])
			check({t_name[k], " exc_code"}, {29'b0, e_code[k]}, {29'b0, exc_code});
	endtask

	// Nothing may move while hold is high
	task automatic freeze_check(input string name);
		check({name, " frozen we"}, {31'b0, last_we}, {31'b0, result_we});
		check({name, " frozen waddr"}, {27'b0, last_waddr}, {27'b0, result_waddr});
		check({name, " frozen data"}, last_data, result_data);
		check({name, " frozen exc_valid"}, {31'b0, last_exc}, {31'b0, exc_valid});
		check({name, " frozen exc_code"}, {29'b0, last_code}, {29'b0, exc_code});
	endtask

	task automatic take_snapshot();
		last_we    = result_we;
		last_waddr = result_waddr;
		last_data  = result_data;
		last_exc   = exc_valid;
		last_code  = exc_code;
	endtask

	// Called 10 ns after an edge, returns 10 ns after the next one
	task automatic step(input int idx, input logic v, input logic h, input logic [31:0] ins);
		int k;
		instr_valid = v;
		hold        = h;
		instr       = ins;
		@(posedge clk);
		#10;
		if (h) begin
			freeze_check(t_name[idx]);
		end else begin
			pend.push_back(idx);
			if (pend.size() > 1) begin
				k = pend.pop_front();
				if (k >= 0)
					compare_result(k); // Slot matured at this edge
			end
		end
		take_snapshot();
	endtask

	initial begin
		int i;
		clk         = 1'b0;
		rst         = 1'b1;
		hold        = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		seed        = 88526;
		errors      = 0;
		checks      = 0;
		cycles      = 0;
		read_patterns();
		limit = n_lines + 40;
		repeat (16) @(posedge clk);
		#10;
		rst = 1'b0;
		take_snapshot();
		for (i = 0; i < n_lines; i++) begin
			step(i, t_valid[i], t_hold[i], t_instr[i]);
			if (t_name[i].substr(0, 2) == "alu" && ($random(seed) & 3) == 0)
				step(-1, 1'b0, 1'b0, 32'h0); // Random gap, no expectation
		end
		repeat (2) step(-1, 1'b0, 1'b0, 32'h0); // Drain
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/idex_patterns.txt
# name instr valid hold | expected two accepted cycles later: we waddr data exc_valid exc_code
# instr and data are hex, the other columns decimal
idle         00000000 0 0 0 0  00000000 0 0
idle         00000000 0 0 0 0  00000000 0 0
ori_zext     34011234 1 0 1 1  00001234 0 0
lui          3c028765 1 0 1 2  87650000 0 0
ori_ffff     3403ffff 1 0 1 3  0000ffff 0 0
alu_addu     00232021 1 0 1 4  00011233 0 0
alu_subu     00232823 1 0 1 5  ffff1235 0 0
alu_and      00233024 1 0 1 6  00001234 0 0
alu_or       00433825 1 0 1 7  8765ffff 0 0
alu_xor      00234026 1 0 1 8  0000edcb 0 0
alu_nor      00234827 1 0 1 9  ffff0000 0 0
alu_slt      0041502a 1 0 1 10 00000001 0 0
alu_sll      00035900 1 0 1 11 000ffff0 0 0
alu_srl      00026202 1 0 1 12 00876500 0 0
fwd_base     240d0005 1 0 1 13 00000005 0 0
fwd_dist1    01ad7021 1 0 1 14 0000000a 0 0
fwd_dist2    01ae7821 1 0 1 15 0000000f 0 0
fwd_r0_write 01ed0023 1 0 0 0  00000000 0 0
fwd_r0_read  000f8021 1 0 1 16 0000000f 0 0
hold_before  26110003 1 0 1 17 00000012 0 0
hold_stall   3412dead 1 1 0 0  00000000 0 0
hold_stall   3412dead 1 1 0 0  00000000 0 0
hold_stall   3412dead 1 1 0 0  00000000 0 0
hold_after   02309021 1 0 1 18 00000021 0 0
hold_next    02519823 1 0 1 19 0000000f 0 0
exc_ovf      0042a020 1 0 0 0  00000000 1 1
exc_flushed  34150bad 1 0 0 0  00000000 0 0
exc_after    34160001 1 0 1 22 00000001 0 0
exc_syscall  0000000c 1 0 0 0  00000000 1 2
exc_flushed  34170bad 1 0 0 0  00000000 0 0
exc_after    02d6c021 1 0 1 24 00000002 0 0
exc_break    0000000d 1 0 0 0  00000000 1 3
exc_flushed  34190bad 1 0 0 0  00000000 0 0
exc_after    341a0007 1 0 1 26 00000007 0 0
exc_reserved fc000000 1 0 0 0  00000000 1 4
exc_flushed  341b0bad 1 0 0 0  00000000 0 0
exc_after    0358e021 1 0 1 28 00000009 0 0

//--- project.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/idex_if.sv
verilog/reg_file.sv
verilog/id_decode.sv
verilog/idex_reg.sv
verilog/ex_stage.sv
verilog/cpu_idex_top.sv
verif/tb_cpu_idex.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_cpu_idex

status=0
./obj_dir/Vtb_cpu_idex > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Testbench failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
